// ==== hw/vdp_pkg.sv ====
/*
 * Shared definitions for the pixel compositor:
 * ARGB4444 colour type, APB register offsets,
 * blender latency and identification word.
 */

`default_nettype none

package vdp_pkg;

    // ARGB4444 pixel
    // a = [15:12], r = [11:8], g = [7:4], b = [3:0]
    typedef logic [15:0] color_t;

    // APB register offsets of the blend register block
    typedef enum logic [7:0] {
        REG_LAYER_ENABLE = 8'h00,
        REG_ALPHA_OVER   = 8'h04,
        REG_BG_COLOR     = 8'h08,
        REG_ID           = 8'h0C
    } reg_addr_e;

    // clocks from blender input to blended output
    // 1 flag and alpha capture
    // 1 lut address
    // 1 lut read
    // 1 multiply
    // 1 sum and round
    localparam int BLEND_LATENCY = 5;

    // read-only identification word, ascii "VDP1"
    localparam logic [31:0] VDP_ID = 32'h5644_5031;

endpackage

`default_nettype wire

// ==== hw/vdp_delay_line.sv ====
/*
 * Fixed-depth shift register that delays a bus by DELAY clocks.
 * Every stage is cleared by reset.
 */

`timescale 1ns/1ns
`default_nettype none

module vdp_delay_line #(
    parameter int DELAY = 1,
    parameter int WIDTH = 1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire [WIDTH-1:0]  in,
    output logic [WIDTH-1:0] out
);

    logic [WIDTH-1:0] stages [DELAY];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DELAY; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < DELAY; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[DELAY-1];

endmodule

`default_nettype wire

// ==== hw/vdp_layer_priority.sv ====
/*
 * Layer priority unit: finds the front visible layer and the
 * visible layer behind it, applies the alpha-over and background
 * rules and registers the colour pair for the blender.
 */

`timescale 1ns/1ns
`default_nettype none

module vdp_layer_priority import vdp_pkg::*; #(
    parameter int NUM_LAYERS = 5
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            pixel_valid,
    input  wire color_t [NUM_LAYERS-1:0]   layer_colors,
    input  wire [NUM_LAYERS-1:0]           layer_enable,
    input  wire [NUM_LAYERS-1:0]           alpha_over,
    input  wire color_t                    bg_color,
    output color_t                         source_color,
    output color_t                         dest_color,
    output logic                           source_enabled,
    output logic                           stage_valid
);

    localparam int IDX_W = $clog2(NUM_LAYERS);

    logic [NUM_LAYERS-1:0] visible;
    logic                  src_found;
    logic                  dst_found;
    logic [IDX_W-1:0]      src_idx;
    logic [IDX_W-1:0]      dst_idx;
    color_t                nxt_source;
    color_t                nxt_dest;
    logic                  nxt_src_en;

    // a layer counts only when enabled and not fully transparent
    always_comb begin
        for (int i = 0; i < NUM_LAYERS; i++) begin
            visible[i] = layer_enable[i] && (layer_colors[i][15:12] != 4'h0);
        end
    end

    // front to back scan, layer 0 is in front
    always_comb begin
        src_found = 1'b0;
        dst_found = 1'b0;
        src_idx   = '0;
        dst_idx   = '0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (visible[i]) begin
                if (!src_found) begin
                    src_found = 1'b1;
                    src_idx   = IDX_W'(i);
                end else if (!dst_found) begin
                    dst_found = 1'b1;
                    dst_idx   = IDX_W'(i);
                end
            end
        end
    end

    always_comb begin
        nxt_source = bg_color;
        nxt_dest   = bg_color;
        nxt_src_en = 1'b0;
        if (src_found) begin
            nxt_source = layer_colors[src_idx];
            if (alpha_over[src_idx]) begin
                nxt_src_en = 1'b1;
                if (dst_found) begin
                    nxt_dest = layer_colors[dst_idx];
                end
            end else begin
                // opaque layer goes straight through as the destination
                nxt_dest = layer_colors[src_idx];
            end
        end
        // destination is always treated as opaque
        nxt_dest[15:12] = 4'hF;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            source_enabled <= 1'b0;
            stage_valid    <= 1'b0;
        end else begin
            source_enabled <= nxt_src_en;
            stage_valid    <= pixel_valid;
        end
    end

    always_ff @(posedge clk) begin
        source_color <= nxt_source;
        dest_color   <= nxt_dest;
    end

    // no stale pixel may leave the stage right after reset
    stage_valid_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !stage_valid
    );

endmodule

`default_nettype wire

// ==== hw/vdp_blender.sv ====
/*
 * Alpha blender: table of scaled alpha factors, registered lookup
 * and a five-stage multiply-and-sum pipeline over padded lanes.
 */

`timescale 1ns/1ns
`default_nettype none

module vdp_blender import vdp_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  wire         source_enabled,
    input  wire color_t source_color,
    input  wire color_t dest_color,
    output color_t      out_color,
    output logic        out_valid
);

    // multiply and sum follow the colour delay
    localparam int COLOR_DELAY = BLEND_LATENCY - 2;

    // table entry layout: {fd[4:0], fs[4:0]}
    // address layout: {dest alpha, gated source alpha}
    logic [9:0]  alpha_lut [256];
    logic [7:0]  lut_addr;
    logic [9:0]  lut_q;

    logic        source_visible;
    logic        source_visible_d;
    logic [3:0]  src_alpha_q;
    logic [3:0]  dst_alpha_q;
    logic [23:0] rgb_d;
    logic [28:0] prod_src;
    logic [28:0] prod_dst;
    logic [5:0]  lane_sum [3];
    logic [11:0] blended;

    function automatic logic [4:0] mapped_alpha(input logic [3:0] a);
        return (a != 4'h0) ? 5'(a) + 5'd1 : 5'd0;
    endfunction

    function automatic logic [9:0] lut_entry(input logic [3:0] dst_a, input logic [3:0] src_a);
        logic [4:0] fs;
        logic [8:0] fd_full;
        fs      = mapped_alpha(src_a);
        fd_full = 9'(5'd16 - fs) * 9'(mapped_alpha(dst_a));
        // divide by 16, truncated
        return {fd_full[8:4], fs};
    endfunction

    // each channel gets an 8 bit lane so one multiply covers all three
    function automatic logic [23:0] pad_lanes(input logic [11:0] rgb);
        return {4'h0, rgb[11:8], 4'h0, rgb[7:4], 4'h0, rgb[3:0]};
    endfunction

    initial begin
        for (int a = 0; a < 256; a++) begin
            alpha_lut[a] = lut_entry(a[7:4], a[3:0]);
        end
    end

    assign source_visible = source_enabled && (source_color[15:12] != 4'h0);

    vdp_delay_line #(
        .DELAY (1),
        .WIDTH (1)
    ) source_visible_dl (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (source_visible),
        .out   (source_visible_d)
    );

    vdp_delay_line #(
        .DELAY (COLOR_DELAY),
        .WIDTH (24)
    ) color_dl (
        .clk   (clk),
        .rst_n (rst_n),
        .in    ({source_color[11:0], dest_color[11:0]}),
        .out   (rgb_d)
    );

    vdp_delay_line #(
        .DELAY (BLEND_LATENCY),
        .WIDTH (1)
    ) valid_dl (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (in_valid),
        .out   (out_valid)
    );

    always_ff @(posedge clk) begin
        src_alpha_q <= source_color[15:12];
        dst_alpha_q <= dest_color[15:12];
        // hidden source selects the fs = 0 row
        lut_addr    <= {dst_alpha_q, source_visible_d ? src_alpha_q : 4'h0};
        lut_q       <= alpha_lut[lut_addr];
        prod_src    <= 29'(pad_lanes(rgb_d[23:12])) * 29'(lut_q[4:0]);
        prod_dst    <= 29'(pad_lanes(rgb_d[11:0])) * 29'(lut_q[9:5]);
        out_color   <= {4'hF, blended};
    end

    // keep one fraction bit per lane, then round
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            lane_sum[ch] = 6'(prod_src[8*ch+3 +: 5]) + 6'(prod_dst[8*ch+3 +: 5]) + 6'd1;
            blended[4*ch +: 4] = lane_sum[ch][4:1];
        end
    end

    // valid path must track the colour path exactly
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, BLEND_LATENCY)
    );

endmodule

`default_nettype wire

// ==== hw/vdp_blend_regs.sv ====
/*
 * APB register block: layer enable mask, alpha-over mask,
 * background colour and read-only identification word.
 * Zero wait states, reads are combinational.
 */

`timescale 1ns/1ns
`default_nettype none

module vdp_blend_regs import vdp_pkg::*; #(
    parameter int NUM_LAYERS = 5
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire [7:0]             paddr,
    input  wire [31:0]            pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [NUM_LAYERS-1:0] layer_enable,
    output logic [NUM_LAYERS-1:0] alpha_over,
    output color_t                bg_color
);

    reg_addr_e   addr;
    logic        addr_ok;
    logic        access;
    logic        wr_en;
    logic [31:0] rd_data;

    assign addr   = reg_addr_e'(paddr);
    assign pready = 1'b1;
    assign access = psel && penable;

    // decode and read mux
    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        case (addr)
            REG_LAYER_ENABLE: rd_data = 32'(layer_enable);
            REG_ALPHA_OVER:   rd_data = 32'(alpha_over);
            REG_BG_COLOR:     rd_data = 32'(bg_color);
            REG_ID:           rd_data = VDP_ID;
            default:          addr_ok = 1'b0;
        endcase
    end

    assign prdata  = (access && !pwrite) ? rd_data : '0;
    assign pslverr = access && (!addr_ok || (pwrite && addr == REG_ID));

    // write lands on the access phase edge
    assign wr_en = access && pready && pwrite && addr_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_enable <= '0;
            alpha_over   <= '0;
            bg_color     <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_LAYER_ENABLE: layer_enable <= pwdata[NUM_LAYERS-1:0];
                REG_ALPHA_OVER:   alpha_over   <= pwdata[NUM_LAYERS-1:0];
                REG_BG_COLOR:     bg_color     <= pwdata[15:0];
                // id is read-only
                default: ;
            endcase
        end
    end

    // error response only inside an access phase
    pslverr_in_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable)
    );

endmodule

`default_nettype wire

// ==== hw/vdp_compositor.sv ====
/*
 * Compositor top level: APB register block, layer priority
 * unit and alpha blender. Six clocks from layers to pixel_out.
 */

`timescale 1ns/1ns
`default_nettype none

module vdp_compositor import vdp_pkg::*; #(
    parameter int NUM_LAYERS = 5
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [7:0]                    paddr,
    input  wire [31:0]                   pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire                          pixel_valid,
    input  wire color_t [NUM_LAYERS-1:0] layer_colors,
    output color_t                       pixel_out,
    output logic                         pixel_out_valid
);

    logic [NUM_LAYERS-1:0] layer_enable;
    logic [NUM_LAYERS-1:0] alpha_over;
    color_t                bg_color;
    color_t                source_color;
    color_t                dest_color;
    logic                  source_enabled;
    logic                  stage_valid;

    vdp_blend_regs #(
        .NUM_LAYERS (NUM_LAYERS)
    ) blend_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .layer_enable (layer_enable),
        .alpha_over   (alpha_over),
        .bg_color     (bg_color)
    );

    vdp_layer_priority #(
        .NUM_LAYERS (NUM_LAYERS)
    ) layer_priority_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pixel_valid    (pixel_valid),
        .layer_colors   (layer_colors),
        .layer_enable   (layer_enable),
        .alpha_over     (alpha_over),
        .bg_color       (bg_color),
        .source_color   (source_color),
        .dest_color     (dest_color),
        .source_enabled (source_enabled),
        .stage_valid    (stage_valid)
    );

    vdp_blender blender_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (stage_valid),
        .source_enabled (source_enabled),
        .source_color   (source_color),
        .dest_color     (dest_color),
        .out_color      (pixel_out),
        .out_valid      (pixel_out_valid)
    );

endmodule

`default_nettype wire

// ==== bench/vdp_clock_gen.sv ====
/*
 * Testbench clock and reset source:
 * free-running clk, rst_n low for the first RESET_CYCLES cycles.
 */

`timescale 1ns/1ns
`default_nettype none

module vdp_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release falls on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        #(PERIOD * RESET_CYCLES);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/vdp_compositor_tb.sv ====
/*
 * Testbench for the pixel compositor: APB transfers, pixel
 * stimulus on the falling edge, reference model and a process
 * that compares every output pixel and its latency.
 */

`timescale 1ns/1ns
`default_nettype none

module vdp_compositor_tb import vdp_pkg::*; ();

    localparam int          NUM_LAYERS   = 5;
    localparam int          PIPE_LATENCY = 1 + BLEND_LATENCY;
    localparam int          TIMEOUT      = 200;
    localparam logic [31:0] LAYER_MASK   = (32'd1 << NUM_LAYERS) - 1;

    typedef color_t [NUM_LAYERS-1:0] layers_t;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [7:0]            paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  pixel_valid;
    layers_t               layer_colors;
    color_t                pixel_out;
    logic                  pixel_out_valid;

    // shadow copies of the register block
    logic [NUM_LAYERS-1:0] shadow_enable;
    logic [NUM_LAYERS-1:0] shadow_alpha_over;
    color_t                shadow_bg;

    color_t                exp_pixel_q [$];
    int                    exp_cycle_q [$];
    string                 exp_name_q [$];
    string                 test_name;
    int                    cycle = 0;

    vdp_clock_gen #(
        .PERIOD       (10),
        .RESET_CYCLES (5)
    ) clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    vdp_compositor #(
        .NUM_LAYERS (NUM_LAYERS)
    ) vdp_compositor_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .pixel_valid     (pixel_valid),
        .layer_colors    (layer_colors),
        .pixel_out       (pixel_out),
        .pixel_out_valid (pixel_out_valid)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int alpha_to_factor(input logic [3:0] a);
        return (a == 4'h0) ? 0 : int'(a) + 1;
    endfunction

    // priority rule followed by the blend rule
    function automatic color_t expected_pixel(input layers_t colors,
                                              input logic [NUM_LAYERS-1:0] en,
                                              input logic [NUM_LAYERS-1:0] ao,
                                              input color_t bg);
        int     src;
        int     dst;
        int     fs;
        int     fd;
        int     v;
        logic   src_on;
        color_t s;
        color_t d;
        color_t result;
        src = -1;
        dst = -1;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (en[i] && colors[i][15:12] != 4'h0) begin
                if (src < 0) begin
                    src = i;
                end else if (dst < 0) begin
                    dst = i;
                end
            end
        end
        s      = bg;
        d      = bg;
        src_on = 1'b0;
        if (src >= 0) begin
            s      = colors[src];
            src_on = ao[src];
            d      = !ao[src] ? colors[src] : ((dst >= 0) ? colors[dst] : bg);
        end
        d[15:12] = 4'hF;
        fs = src_on ? alpha_to_factor(s[15:12]) : 0;
        fd = ((16 - fs) * alpha_to_factor(d[15:12])) / 16;
        result[15:12] = 4'hF;
        for (int ch = 0; ch < 3; ch++) begin
            v = (((int'(s[4*ch +: 4]) * fs) >> 3) + ((int'(d[4*ch +: 4]) * fd) >> 3) + 1) >> 1;
            result[4*ch +: 4] = 4'(v);
        end
        return result;
    endfunction

    function automatic layers_t random_layers();
        layers_t l;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            l[i] = 16'($urandom);
            // roughly one layer in four fully transparent
            if ($urandom_range(3) == 0) begin
                l[i][15:12] = 4'h0;
            end
        end
        return l;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic update_shadow(input logic [7:0] addr, input logic [31:0] data);
        case (addr)
            REG_LAYER_ENABLE: shadow_enable     = data[NUM_LAYERS-1:0];
            REG_ALPHA_OVER:   shadow_alpha_over = data[NUM_LAYERS-1:0];
            REG_BG_COLOR:     shadow_bg         = data[15:0];
            default: ;
        endcase
    endtask

    // on a write data is pwdata, on a read the expected prdata
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data, input logic exp_err);
        @(negedge clk);
        pixel_valid = 1'b0;
        psel        = 1'b1;
        pwrite      = write;
        paddr       = addr;
        pwdata      = write ? data : 32'h0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        check_value("pready", 32'd1, 32'(pready));
        check_value("pslverr", 32'(exp_err), 32'(pslverr));
        if (!write && !exp_err) begin
            check_value("prdata", data, prdata);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (write && !exp_err) begin
            update_shadow(addr, data);
        end
    endtask

    // caller sits on a falling edge
    task automatic drive_layers(input logic valid, input layers_t l);
        pixel_valid  = valid;
        layer_colors = l;
        if (valid) begin
            exp_pixel_q.push_back(expected_pixel(l, shadow_enable, shadow_alpha_over, shadow_bg));
            exp_cycle_q.push_back(cycle);
            exp_name_q.push_back(test_name);
        end
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            drive_layers(1'b1, random_layers());
        end
    endtask

    // register write overlapping a continuous pixel stream
    task automatic stream_with_write(input logic [7:0] addr, input logic [31:0] data,
                                     input int count, input int write_at);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            if (i == write_at) begin
                psel   = 1'b1;
                pwrite = 1'b1;
                paddr  = addr;
                pwdata = data;
            end
            if (i == write_at + 1) begin
                penable = 1'b1;
            end
            if (i == write_at + 2) begin
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
                update_shadow(addr, data);
            end
            drive_layers(1'b1, random_layers());
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(negedge clk);
        pixel_valid = 1'b0;
        while (exp_pixel_q.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_pixel_q.size() != 0) begin
            fail_now("timeout waiting for the pixel pipeline to drain");
        end
    endtask

    // oldest pixel in flight against each valid output
    always @(negedge clk) begin : compare_outputs
        color_t exp_pixel;
        int     sent_at;
        string  name;
        if (rst_n && pixel_out_valid) begin
            if (exp_pixel_q.size() == 0) begin
                fail_now("pixel_out_valid high with no pixel in flight");
            end else begin
                exp_pixel = exp_pixel_q.pop_front();
                sent_at   = exp_cycle_q.pop_front();
                name      = exp_name_q.pop_front();
                assert (pixel_out == exp_pixel) else begin
                    $display("mismatch %s pixel expected %h actual %h", name, exp_pixel, pixel_out);
                    $display("STATUS: FAIL");
                    $fatal(1);
                end
                assert (cycle - sent_at == PIPE_LATENCY) else begin
                    $display("mismatch %s latency expected %0d actual %0d",
                             name, PIPE_LATENCY, cycle - sent_at);
                    $display("STATUS: FAIL");
                    $fatal(1);
                end
            end
        end
    end

    initial begin : stimulus
        layers_t l;
        int      n;
        void'($urandom(32'h01ec_9f1e));
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        paddr             = 8'h00;
        pwdata            = 32'h0;
        pixel_valid       = 1'b0;
        layer_colors      = '0;
        shadow_enable     = '0;
        shadow_alpha_over = '0;
        shadow_bg         = '0;
        test_name         = "reset";
        n = 0;
        while (!rst_n && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            fail_now("reset was never released");
        end
        repeat (PIPE_LATENCY + 2) begin
            @(negedge clk);
            check_value("pixel_out_valid", 32'd0, 32'(pixel_out_valid));
        end

        test_name = "register access";
        apb_transfer(1'b1, REG_LAYER_ENABLE, 32'hFFFF_FFF5, 1'b0);
        apb_transfer(1'b0, REG_LAYER_ENABLE, 32'hFFFF_FFF5 & LAYER_MASK, 1'b0);
        apb_transfer(1'b1, REG_ALPHA_OVER, 32'h0000_00EA, 1'b0);
        apb_transfer(1'b0, REG_ALPHA_OVER, 32'h0000_00EA & LAYER_MASK, 1'b0);
        apb_transfer(1'b1, REG_BG_COLOR, 32'h1234_5678, 1'b0);
        apb_transfer(1'b0, REG_BG_COLOR, 32'h0000_5678, 1'b0);
        apb_transfer(1'b0, REG_ID, VDP_ID, 1'b0);
        apb_transfer(1'b1, REG_ID, 32'h0, 1'b1);
        apb_transfer(1'b0, REG_ID, VDP_ID, 1'b0);
        apb_transfer(1'b0, 8'h10, 32'h0, 1'b1);
        apb_transfer(1'b1, 8'h02, 32'hFFFF_FFFF, 1'b1);
        apb_transfer(1'b0, REG_LAYER_ENABLE, 32'hFFFF_FFF5 & LAYER_MASK, 1'b0);

        test_name = "opaque priority";
        apb_transfer(1'b1, REG_ALPHA_OVER, 32'h0, 1'b0);
        apb_transfer(1'b1, REG_LAYER_ENABLE, LAYER_MASK, 1'b0);
        apb_transfer(1'b1, REG_BG_COLOR, 32'h0000_3ABC, 1'b0);
        // k front layers transparent, the last pass shows the background
        for (int k = 0; k <= NUM_LAYERS; k++) begin
            l = random_layers();
            for (int i = 0; i < NUM_LAYERS; i++) begin
                if (i < k) begin
                    l[i][15:12] = 4'h0;
                end else if (l[i][15:12] == 4'h0) begin
                    l[i][15:12] = 4'h9;
                end
            end
            @(negedge clk);
            drive_layers(1'b1, l);
        end
        apb_transfer(1'b1, REG_LAYER_ENABLE, 32'h0000_001C, 1'b0);
        send_random(8);
        apb_transfer(1'b1, REG_LAYER_ENABLE, 32'h0, 1'b0);
        send_random(4);
        apb_transfer(1'b1, REG_LAYER_ENABLE, 32'h0000_0012, 1'b0);
        send_random(8);

        test_name = "alpha blend";
        for (int r = 0; r < 4; r++) begin
            apb_transfer(1'b1, REG_LAYER_ENABLE, $urandom, 1'b0);
            apb_transfer(1'b1, REG_ALPHA_OVER, (r == 0) ? LAYER_MASK : $urandom, 1'b0);
            apb_transfer(1'b1, REG_BG_COLOR, $urandom, 1'b0);
            send_random(25);
        end

        test_name = "streaming";
        for (int b = 0; b < 12; b++) begin
            send_random($urandom_range(8, 1));
            repeat ($urandom_range(3, 0)) begin
                @(negedge clk);
                drive_layers(1'b0, random_layers());
            end
        end
        drain();

        test_name = "mask change";
        apb_transfer(1'b1, REG_LAYER_ENABLE, LAYER_MASK, 1'b0);
        apb_transfer(1'b1, REG_ALPHA_OVER, LAYER_MASK, 1'b0);
        stream_with_write(REG_LAYER_ENABLE, 32'h0000_0016, 20, 6);
        stream_with_write(REG_ALPHA_OVER, 32'h0000_0005, 20, 8);
        drain();
        // nothing more may come out once the pipeline is empty
        repeat (PIPE_LATENCY) @(negedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/vdp_pkg.sv
hw/vdp_delay_line.sv
hw/vdp_layer_priority.sv
hw/vdp_blender.sv
hw/vdp_blend_regs.sv
hw/vdp_compositor.sv
bench/vdp_clock_gen.sv
bench/vdp_compositor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the compositor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module vdp_compositor_tb \
    -f sources.f \
    -o vdp_compositor_sim

./obj_dir/vdp_compositor_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
